// File: logic/write_engine_pkg.sv
//////////////////////////////
// Widths, command kinds and job constants of the write engine
// Addresses are byte addresses, one write command covers one cache line
//////////////////////////////

`default_nettype none

package write_engine_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	// Full byte address
	typedef logic [63:0] addr_t;

	// Cache line count, also used for job length and lines_done
	typedef logic [15:0] lines_t;

	//////////////////////////////
	// Command kinds
	//////////////////////////////

	typedef enum logic [1:0] {
		KIND_NONE     = 2'd0,
		// Prefetch of one page
		KIND_TOUCH    = 2'd1,
		// Write without cache allocation
		KIND_WRITE_NA = 2'd2,
		// Write with allocation
		KIND_WRITE_MS = 2'd3
	} cmd_kind_t;

	//////////////////////////////
	// Job constants
	//////////////////////////////

	// Bytes per cache line
	localparam int LINE_BYTES = 128;

	// Each line arrives as two halves
	localparam int HALF_BITS = 512;

	// Cache lines per page for touch commands
	localparam int DEFAULT_PAGE_LINES = 32;

	// Entries per data half buffer
	localparam int DEFAULT_BUFFER_DEPTH = 16;

endpackage

`default_nettype wire

// File: logic/sync_fifo.sv
//////////////////////////////
// Show-ahead buffer, data_out is valid whenever empty is low
// Pushes while full and pops while empty are dropped
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int width           = 512,
	parameter int depth           = 16,
	parameter int buffer_headroom = 4
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [width-1:0] data_in,
	input  logic             pop,
	output logic [width-1:0] data_out,
	output logic             full,
	output logic             almost_full,
	output logic             empty
);

	localparam int ptr_bits   = (depth > 1) ? $clog2(depth) : 1;
	localparam int count_bits = $clog2(depth + 1);

	logic [width-1:0]      mem [depth];
	logic [ptr_bits-1:0]   wr_ptr;
	logic [ptr_bits-1:0]   rd_ptr;
	logic [count_bits-1:0] count;
	logic                  do_push;
	logic                  do_pop;

	assign do_push     = push && !full;
	assign do_pop      = pop && !empty;
	assign full        = (int'(count) == depth);
	assign empty       = (count == '0);
	// Fewer than buffer_headroom entries free
	assign almost_full = ((depth - int'(count)) < buffer_headroom);
	// Head entry shown without a pop
	assign data_out    = mem[rd_ptr];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				if (int'(wr_ptr) == depth - 1)
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				if (int'(rd_ptr) == depth - 1)
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

endmodule

`default_nettype wire

// File: logic/prefetch_page_sequencer.sv
//////////////////////////////
// One touch command per page, the last page may be partial
// pf_start must not arrive while a previous job is still draining
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module prefetch_page_sequencer import write_engine_pkg::*; #(
	parameter int page_lines = DEFAULT_PAGE_LINES
) (
	input  logic   clock,
	input  logic   rstn,
	input  logic   pf_start,
	input  addr_t  job_base,
	input  lines_t job_lines,
	input  logic   pf_cmd_almost_full,
	input  logic   pf_rsp_valid,
	output logic   pf_cmd_valid,
	output addr_t  pf_cmd_address,
	output lines_t pf_cmd_lines,
	output logic   pf_drained
);

	localparam lines_t page_size   = lines_t'(page_lines);
	localparam addr_t  page_stride = addr_t'(page_lines * LINE_BYTES);

	logic   active;
	addr_t  base_q;
	addr_t  page_offset;
	lines_t remaining;
	lines_t sent_count;
	lines_t answered_count;
	lines_t chunk;
	logic   issue;

	// Full page or whatever is left
	assign chunk = (remaining > page_size) ? page_size : remaining;
	assign issue = active && (remaining != '0) && !pf_cmd_almost_full;

	//////////////////////////////
	// Page walk and drain tracking
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active         <= 1'b0;
			page_offset    <= '0;
			remaining      <= '0;
			sent_count     <= '0;
			answered_count <= '0;
			pf_cmd_valid   <= 1'b0;
			pf_drained     <= 1'b0;
		end else begin
			pf_drained   <= 1'b0;
			pf_cmd_valid <= issue;
			if (pf_start) begin
				active         <= 1'b1;
				page_offset    <= '0;
				remaining      <= job_lines;
				sent_count     <= '0;
				answered_count <= '0;
			end else begin
				if (issue) begin
					remaining   <= remaining - chunk;
					page_offset <= page_offset + page_stride;
				end
				// Count commands as they leave
				if (pf_cmd_valid)
					sent_count <= sent_count + 1'b1;
				if (pf_rsp_valid)
					answered_count <= answered_count + 1'b1;
				// All pages out and every one answered
				if (active && (remaining == '0) && !pf_cmd_valid &&
						(sent_count == answered_count)) begin
					active     <= 1'b0;
					pf_drained <= 1'b1;
				end
			end
		end
	end

	// Command payload
	always_ff @(posedge clock) begin
		if (pf_start)
			base_q <= job_base;
		if (issue) begin
			pf_cmd_address <= base_q + page_offset;
			pf_cmd_lines   <= chunk;
		end
	end

endmodule

`default_nettype wire

// File: logic/write_engine_control.sv
//////////////////////////////
// Job FSM, the job is taken only in idle or done
// A write command leaves one cycle after its pop, one line per command
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module write_engine_control import write_engine_pkg::*; #(
	parameter int data_width   = HALF_BITS,
	parameter int buffer_depth = DEFAULT_BUFFER_DEPTH
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  job_start,
	input  addr_t                 job_base,
	input  lines_t                job_lines,
	input  logic                  job_prefetch,
	input  logic                  job_allocate,
	input  logic                  data_0_valid,
	input  logic [data_width-1:0] data_0,
	input  logic                  data_1_valid,
	input  logic [data_width-1:0] data_1,
	input  logic                  wr_cmd_almost_full,
	input  logic                  wr_rsp_valid,
	input  lines_t                wr_rsp_lines,
	input  logic                  pf_drained,
	output logic                  data_full,
	output logic                  pf_start,
	output addr_t                 pf_base,
	output lines_t                pf_lines,
	output logic                  wr_cmd_valid,
	output cmd_kind_t             wr_cmd_kind,
	output addr_t                 wr_cmd_address,
	output lines_t                wr_cmd_lines,
	output logic [data_width-1:0] wr_data_0,
	output logic [data_width-1:0] wr_data_1,
	output lines_t                lines_done,
	output logic                  job_done,
	output logic                  busy
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LATCH,
		ST_PF_WAIT,
		ST_WR_START,
		ST_WR_REQ,
		ST_WR_PEND,
		ST_DONE
	} state_t;

	state_t                state;
	addr_t                 base_q;
	lines_t                lines_q;
	logic                  prefetch_q;
	logic                  allocate_q;
	lines_t                remaining;
	addr_t                 wr_offset;
	lines_t                sent_count;
	lines_t                answered_count;
	logic [data_width-1:0] head_0;
	logic [data_width-1:0] head_1;
	logic                  empty_0;
	logic                  empty_1;
	logic                  almost_full_0;
	logic                  almost_full_1;
	logic                  buf_0_full;
	logic                  buf_1_full;
	logic                  accept;
	logic                  data_pop;
	logic                  write_drained;

	assign accept   = job_start && ((state == ST_IDLE) || (state == ST_DONE));
	assign busy     = (state != ST_IDLE) && (state != ST_DONE);
	assign job_done = (state == ST_DONE);
	assign pf_start = (state == ST_LATCH) && prefetch_q && (lines_q != '0);
	assign pf_base  = base_q;
	assign pf_lines = lines_q;

	// Both halves present, room downstream, lines left
	assign data_pop = (state == ST_WR_REQ) && !empty_0 && !empty_1 &&
			!wr_cmd_almost_full && (remaining != '0);
	assign write_drained = (remaining == '0) && !wr_cmd_valid &&
			(sent_count == answered_count);
	assign data_full = almost_full_0 || almost_full_1;

	//////////////////////////////
	// Job FSM and counters
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state          <= ST_IDLE;
			remaining      <= '0;
			wr_offset      <= '0;
			sent_count     <= '0;
			answered_count <= '0;
			wr_cmd_valid   <= 1'b0;
			lines_done     <= '0;
		end else begin
			wr_cmd_valid <= data_pop;
			case (state)
				ST_IDLE, ST_DONE: begin
					if (accept)
						state <= ST_LATCH;
					else
						state <= ST_IDLE;
				end
				ST_LATCH: begin
					if (lines_q == '0)
						state <= ST_DONE;
					else if (prefetch_q)
						state <= ST_PF_WAIT;
					else
						state <= ST_WR_START;
				end
				ST_PF_WAIT: begin
					if (pf_drained)
						state <= ST_WR_START;
				end
				ST_WR_START: begin
					remaining <= lines_q;
					wr_offset <= '0;
					state     <= ST_WR_REQ;
				end
				ST_WR_REQ: begin
					if (data_pop && (remaining == lines_t'(1)))
						state <= ST_WR_PEND;
				end
				ST_WR_PEND: begin
					if (write_drained)
						state <= ST_DONE;
				end
				default: state <= ST_IDLE;
			endcase
			if (data_pop) begin
				remaining <= remaining - 1'b1;
				wr_offset <= wr_offset + addr_t'(LINE_BYTES);
			end
			// Sent counts commands on the port, not pops
			if (state == ST_WR_START) begin
				sent_count     <= '0;
				answered_count <= '0;
			end else begin
				if (wr_cmd_valid)
					sent_count <= sent_count + 1'b1;
				if (wr_rsp_valid)
					answered_count <= answered_count + 1'b1;
			end
			if (accept)
				lines_done <= '0;
			else if (wr_rsp_valid)
				lines_done <= lines_done + wr_rsp_lines;
		end
	end

	// Job fields and command payload
	always_ff @(posedge clock) begin
		if (accept) begin
			base_q     <= job_base;
			lines_q    <= job_lines;
			prefetch_q <= job_prefetch;
			allocate_q <= job_allocate;
		end
		if (data_pop) begin
			wr_cmd_address <= base_q + wr_offset;
			wr_cmd_kind    <= allocate_q ? KIND_WRITE_MS : KIND_WRITE_NA;
			wr_cmd_lines   <= lines_t'(1);
			wr_data_0      <= head_0;
			wr_data_1      <= head_1;
		end
	end

	//////////////////////////////
	// Data half buffers
	//////////////////////////////

	sync_fifo #(
		.width(data_width),
		.depth(buffer_depth)
	) u_data_0_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (data_0_valid),
		.data_in    (data_0),
		.pop        (data_pop),
		.data_out   (head_0),
		.full       (buf_0_full),
		.almost_full(almost_full_0),
		.empty      (empty_0)
	);

	sync_fifo #(
		.width(data_width),
		.depth(buffer_depth)
	) u_data_1_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (data_1_valid),
		.data_in    (data_1),
		.pop        (data_pop),
		.data_out   (head_1),
		.full       (buf_1_full),
		.almost_full(almost_full_1),
		.empty      (empty_1)
	);

endmodule

`default_nettype wire

// File: logic/write_engine_top.sv
//////////////////////////////
// Write engine with page prefetch, downstream buffers need headroom of 2
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module write_engine_top import write_engine_pkg::*; #(
	parameter int data_width   = HALF_BITS,
	parameter int page_lines   = DEFAULT_PAGE_LINES,
	parameter int buffer_depth = DEFAULT_BUFFER_DEPTH
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  job_start,
	input  addr_t                 job_base,
	input  lines_t                job_lines,
	input  logic                  job_prefetch,
	input  logic                  job_allocate,
	input  logic                  data_0_valid,
	input  logic [data_width-1:0] data_0,
	input  logic                  data_1_valid,
	input  logic [data_width-1:0] data_1,
	input  logic                  wr_cmd_almost_full,
	input  logic                  pf_cmd_almost_full,
	input  logic                  wr_rsp_valid,
	input  lines_t                wr_rsp_lines,
	input  logic                  pf_rsp_valid,
	output logic                  data_full,
	output logic                  wr_cmd_valid,
	output cmd_kind_t             wr_cmd_kind,
	output addr_t                 wr_cmd_address,
	output lines_t                wr_cmd_lines,
	output logic [data_width-1:0] wr_data_0,
	output logic [data_width-1:0] wr_data_1,
	output logic                  pf_cmd_valid,
	output addr_t                 pf_cmd_address,
	output lines_t                pf_cmd_lines,
	output lines_t                lines_done,
	output logic                  job_done,
	output logic                  busy
);

	// Control to sequencer handoff
	logic   pf_start;
	logic   pf_drained;
	addr_t  pf_base;
	lines_t pf_lines;

	write_engine_control #(
		.data_width  (data_width),
		.buffer_depth(buffer_depth)
	) u_write_engine_control (
		.clock             (clock),
		.rstn              (rstn),
		.job_start         (job_start),
		.job_base          (job_base),
		.job_lines         (job_lines),
		.job_prefetch      (job_prefetch),
		.job_allocate      (job_allocate),
		.data_0_valid      (data_0_valid),
		.data_0            (data_0),
		.data_1_valid      (data_1_valid),
		.data_1            (data_1),
		.wr_cmd_almost_full(wr_cmd_almost_full),
		.wr_rsp_valid      (wr_rsp_valid),
		.wr_rsp_lines      (wr_rsp_lines),
		.pf_drained        (pf_drained),
		.data_full         (data_full),
		.pf_start          (pf_start),
		.pf_base           (pf_base),
		.pf_lines          (pf_lines),
		.wr_cmd_valid      (wr_cmd_valid),
		.wr_cmd_kind       (wr_cmd_kind),
		.wr_cmd_address    (wr_cmd_address),
		.wr_cmd_lines      (wr_cmd_lines),
		.wr_data_0         (wr_data_0),
		.wr_data_1         (wr_data_1),
		.lines_done        (lines_done),
		.job_done          (job_done),
		.busy              (busy)
	);

	prefetch_page_sequencer #(
		.page_lines(page_lines)
	) u_prefetch_page_sequencer (
		.clock             (clock),
		.rstn              (rstn),
		.pf_start          (pf_start),
		.job_base          (pf_base),
		.job_lines         (pf_lines),
		.pf_cmd_almost_full(pf_cmd_almost_full),
		.pf_rsp_valid      (pf_rsp_valid),
		.pf_cmd_valid      (pf_cmd_valid),
		.pf_cmd_address    (pf_cmd_address),
		.pf_cmd_lines      (pf_cmd_lines),
		.pf_drained        (pf_drained)
	);

endmodule

`default_nettype wire

// File: tb/write_engine_checker.sv
//////////////////////////////
// Bound into the control block, sees its internal buffer flags
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module write_engine_checker (
	input logic clock,
	input logic rstn,
	input logic wr_cmd_valid,
	input logic wr_cmd_almost_full,
	input logic job_done,
	input logic busy,
	input logic data_0_valid,
	input logic data_1_valid,
	input logic buf_0_full,
	input logic buf_1_full
);

	// Failed assertions, read by the testbench at the end
	int fail_count = 0;

	// Outputs quiet while reset is held
	quiet_in_reset: assert property (@(posedge clock)
			!rstn |-> !wr_cmd_valid && !job_done && !busy)
		else begin
			fail_count++;
			$error("valid, job_done or busy high during reset");
		end

	// A command needs a pop, and no pop happens while the command buffer is nearly full
	no_issue_after_almost_full: assert property (@(posedge clock) disable iff (!rstn)
			wr_cmd_valid |-> !$past(wr_cmd_almost_full))
		else begin
			fail_count++;
			$error("write command issued after a cycle with wr_cmd_almost_full high");
		end

	single_cycle_done: assert property (@(posedge clock) disable iff (!rstn)
			job_done |=> !job_done)
		else begin
			fail_count++;
			$error("job_done held for more than one cycle");
		end

	// Producer honours data_full
	no_push_when_full_0: assert property (@(posedge clock) disable iff (!rstn)
			data_0_valid |-> !buf_0_full)
		else begin
			fail_count++;
			$error("data half 0 pushed into a full buffer");
		end

	no_push_when_full_1: assert property (@(posedge clock) disable iff (!rstn)
			data_1_valid |-> !buf_1_full)
		else begin
			fail_count++;
			$error("data half 1 pushed into a full buffer");
		end

endmodule

`default_nettype wire

// File: tb/write_engine_monitor.sv
//////////////////////////////
// Expected commands come from the job fields and the pushed data
// A job is accepted only when none is running or on its job_done cycle
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module write_engine_monitor import write_engine_pkg::*; #(
	parameter int data_width   = HALF_BITS,
	parameter int page_lines   = DEFAULT_PAGE_LINES,
	parameter int buffer_depth = DEFAULT_BUFFER_DEPTH
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  job_start,
	input  addr_t                 job_base,
	input  lines_t                job_lines,
	input  logic                  job_prefetch,
	input  logic                  job_allocate,
	input  int                    expected_touches,
	input  logic                  data_0_valid,
	input  logic [data_width-1:0] data_0,
	input  logic                  data_1_valid,
	input  logic [data_width-1:0] data_1,
	input  logic                  data_full,
	input  logic                  wr_cmd_valid,
	input  cmd_kind_t             wr_cmd_kind,
	input  addr_t                 wr_cmd_address,
	input  lines_t                wr_cmd_lines,
	input  logic [data_width-1:0] wr_data_0,
	input  logic [data_width-1:0] wr_data_1,
	input  logic                  pf_cmd_valid,
	input  addr_t                 pf_cmd_address,
	input  lines_t                pf_cmd_lines,
	input  lines_t                lines_done,
	input  logic                  job_done,
	input  logic                  busy,
	output int                    tests_done,
	output int                    tests_failed,
	output int                    error_count
);

	localparam int value_bits = (data_width > 64) ? data_width : 64;
	// Free entries below which a data buffer counts as nearly full
	localparam int headroom   = 4;

	logic [data_width-1:0] pushed_0 [$];
	logic [data_width-1:0] pushed_1 [$];
	logic   in_job;
	addr_t  exp_base;
	lines_t exp_lines;
	logic   exp_prefetch;
	logic   exp_allocate;
	int     exp_touches;
	int     write_count;
	int     touch_count;
	int     test_errors;
	int     job_cycles;
	int     held_0;
	int     held_1;

	task automatic check_value(input string name, input logic [value_bits-1:0] expected,
			input logic [value_bits-1:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
			test_errors++;
			error_count++;
		end
	endtask

	task automatic report_problem(input string text);
		$display("%0t ns: %s", $time, text);
		test_errors++;
		error_count++;
	endtask

	// Pages the current job must touch
	function automatic int rule_pages();
		if (!exp_prefetch)
			return 0;
		return (int'(exp_lines) + page_lines - 1) / page_lines;
	endfunction

	// Occupancy of one data buffer against its headroom
	function automatic logic nearly_full(input int held);
		return (buffer_depth - held) < headroom;
	endfunction

	task automatic check_touch();
		addr_t exp_address;
		int    left;
		if (!in_job || touch_count >= rule_pages()) begin
			report_problem("touch command that the job does not call for");
		end else begin
			if (write_count != 0)
				report_problem("touch command after the first write command");
			left        = int'(exp_lines) - touch_count * page_lines;
			exp_address = exp_base + addr_t'(touch_count) * page_lines * LINE_BYTES;
			check_value("pf_cmd_address", exp_address, pf_cmd_address);
			check_value("pf_cmd_lines", (left < page_lines) ? left : page_lines, pf_cmd_lines);
		end
		touch_count++;
	endtask

	task automatic check_write();
		addr_t     exp_address;
		cmd_kind_t exp_kind;
		if (!in_job || write_count >= int'(exp_lines)) begin
			report_problem("write command beyond the lines of the job");
		end else if (pushed_0.size() == 0 || pushed_1.size() == 0) begin
			report_problem("write command with no pushed data left");
		end else begin
			if (touch_count < rule_pages())
				report_problem("write command before all touch commands");
			exp_address = exp_base + addr_t'(write_count) * LINE_BYTES;
			exp_kind    = exp_allocate ? KIND_WRITE_MS : KIND_WRITE_NA;
			check_value("wr_cmd_address", exp_address, wr_cmd_address);
			check_value("wr_cmd_kind", exp_kind, wr_cmd_kind);
			check_value("wr_cmd_lines", 1, wr_cmd_lines);
			check_value("wr_data_0", pushed_0.pop_front(), wr_data_0);
			check_value("wr_data_1", pushed_1.pop_front(), wr_data_1);
		end
		write_count++;
	endtask

	task automatic finish_test();
		if (!in_job) begin
			report_problem("job_done pulsed with no job in progress");
		end else begin
			check_value("write count", exp_lines, write_count);
			check_value("touch count", exp_touches, touch_count);
			check_value("lines_done", exp_lines, lines_done);
			if (pushed_0.size() != 0 || pushed_1.size() != 0)
				report_problem("pushed data left unused after job_done");
			// Empty job runs latch then done
			if (exp_lines == '0)
				check_value("job_done latency", 2, job_cycles);
		end
		$display("test %0d: %0d lines, %0d touch and %0d write commands, %s", tests_done,
				exp_lines, touch_count, write_count, (test_errors == 0) ? "ok" : "failed");
		tests_done++;
		if (test_errors != 0)
			tests_failed++;
	endtask

	always @(posedge clock) begin : watch
		logic accepted;
		if (!rstn) begin
			in_job       = 1'b0;
			held_0       = 0;
			held_1       = 0;
			tests_done   = 0;
			tests_failed = 0;
			error_count  = 0;
			pushed_0.delete();
			pushed_1.delete();
		end else begin
			accepted = job_start && (!in_job || job_done);
			// A write command means both heads left one cycle earlier
			if (wr_cmd_valid) begin
				held_0--;
				held_1--;
			end
			check_value("data_full", nearly_full(held_0) || nearly_full(held_1), data_full);
			if (data_0_valid) begin
				pushed_0.push_back(data_0);
				held_0++;
			end
			if (data_1_valid) begin
				pushed_1.push_back(data_1);
				held_1++;
			end
			if (in_job)
				job_cycles++;
			check_value("busy", in_job && !job_done, busy);
			if (pf_cmd_valid)
				check_touch();
			if (wr_cmd_valid)
				check_write();
			if (job_done)
				finish_test();
			if (accepted) begin
				in_job       = 1'b1;
				exp_base     = job_base;
				exp_lines    = job_lines;
				exp_prefetch = job_prefetch;
				exp_allocate = job_allocate;
				exp_touches  = expected_touches;
				write_count  = 0;
				touch_count  = 0;
				test_errors  = 0;
				job_cycles   = 0;
			end else if (job_done) begin
				in_job = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/write_engine_tb.sv
//////////////////////////////
// Jobs run one after another, each must end in job_done
// Responses return out of order after a short random delay
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module write_engine_tb
	import write_engine_pkg::*;
();

	localparam int data_width   = HALF_BITS;
	localparam int page_lines   = 32;
	localparam int buffer_depth = 16;
	localparam int num_jobs     = 7;
	localparam int busy_timeout = 20;
	localparam int done_timeout = 4000;

	logic                  clock = 1'b0;
	logic                  rstn;
	logic                  job_start = 1'b0;
	addr_t                 job_base = '0;
	lines_t                job_lines = '0;
	logic                  job_prefetch = 1'b0;
	logic                  job_allocate = 1'b0;
	logic                  data_0_valid = 1'b0;
	logic [data_width-1:0] data_0 = '0;
	logic                  data_1_valid = 1'b0;
	logic [data_width-1:0] data_1 = '0;
	logic                  wr_cmd_almost_full = 1'b0;
	logic                  pf_cmd_almost_full = 1'b0;
	logic                  wr_rsp_valid = 1'b0;
	lines_t                wr_rsp_lines = '0;
	logic                  pf_rsp_valid = 1'b0;
	logic                  data_full;
	logic                  wr_cmd_valid;
	cmd_kind_t             wr_cmd_kind;
	addr_t                 wr_cmd_address;
	lines_t                wr_cmd_lines;
	logic [data_width-1:0] wr_data_0;
	logic [data_width-1:0] wr_data_1;
	logic                  pf_cmd_valid;
	addr_t                 pf_cmd_address;
	lines_t                pf_cmd_lines;
	lines_t                lines_done;
	logic                  job_done;
	logic                  busy;

	integer seed = 32'h9140f83f;
	int     expected_touches = 0;
	logic   apply_pressure = 1'b0;
	int     pushes_requested = 0;
	int     pushes_done = 0;
	int     cycle_count = 0;
	int     wr_due [$];
	lines_t wr_due_lines [$];
	int     pf_due [$];
	bit     hung = 1'b0;
	int     tests_done;
	int     tests_failed;
	int     value_errors;

	//////////////////////////////
	// Job table
	//////////////////////////////

	int tbl_lines [num_jobs];
	bit tbl_prefetch [num_jobs];
	bit tbl_allocate [num_jobs];
	bit tbl_pressure [num_jobs];
	bit tbl_restart [num_jobs];
	int tbl_touches [num_jobs];

	task automatic set_row(input int row, input int lines, input bit prefetch,
			input bit allocate, input bit pressure, input bit restart, input int touches);
		tbl_lines[row]    = lines;
		tbl_prefetch[row] = prefetch;
		tbl_allocate[row] = allocate;
		tbl_pressure[row] = pressure;
		tbl_restart[row]  = restart;
		tbl_touches[row]  = touches;
	endtask

	task automatic fill_table();
		// Row, lines, prefetch, allocate, pressure, restart, touches
		set_row(0, 5, 0, 1, 0, 0, 0);
		set_row(1, 5, 0, 0, 0, 0, 0);
		set_row(2, 70, 1, 1, 0, 0, 3);
		set_row(3, 70, 1, 0, 1, 0, 3);
		set_row(4, 0, 1, 0, 0, 0, 0);
		set_row(5, 12, 0, 1, 1, 1, 0);
		set_row(6, 40, 1, 1, 1, 1, 2);
	endtask

	//////////////////////////////
	// DUT and monitor
	//////////////////////////////

	write_engine_top #(
		.data_width  (data_width),
		.page_lines  (page_lines),
		.buffer_depth(buffer_depth)
	) u_write_engine_top (
		.clock             (clock),
		.rstn              (rstn),
		.job_start         (job_start),
		.job_base          (job_base),
		.job_lines         (job_lines),
		.job_prefetch      (job_prefetch),
		.job_allocate      (job_allocate),
		.data_0_valid      (data_0_valid),
		.data_0            (data_0),
		.data_1_valid      (data_1_valid),
		.data_1            (data_1),
		.wr_cmd_almost_full(wr_cmd_almost_full),
		.pf_cmd_almost_full(pf_cmd_almost_full),
		.wr_rsp_valid      (wr_rsp_valid),
		.wr_rsp_lines      (wr_rsp_lines),
		.pf_rsp_valid      (pf_rsp_valid),
		.data_full         (data_full),
		.wr_cmd_valid      (wr_cmd_valid),
		.wr_cmd_kind       (wr_cmd_kind),
		.wr_cmd_address    (wr_cmd_address),
		.wr_cmd_lines      (wr_cmd_lines),
		.wr_data_0         (wr_data_0),
		.wr_data_1         (wr_data_1),
		.pf_cmd_valid      (pf_cmd_valid),
		.pf_cmd_address    (pf_cmd_address),
		.pf_cmd_lines      (pf_cmd_lines),
		.lines_done        (lines_done),
		.job_done          (job_done),
		.busy              (busy)
	);

	write_engine_monitor #(
		.data_width  (data_width),
		.page_lines  (page_lines),
		.buffer_depth(buffer_depth)
	) u_write_engine_monitor (
		.clock           (clock),
		.rstn            (rstn),
		.job_start       (job_start),
		.job_base        (job_base),
		.job_lines       (job_lines),
		.job_prefetch    (job_prefetch),
		.job_allocate    (job_allocate),
		.expected_touches(expected_touches),
		.data_0_valid    (data_0_valid),
		.data_0          (data_0),
		.data_1_valid    (data_1_valid),
		.data_1          (data_1),
		.data_full       (data_full),
		.wr_cmd_valid    (wr_cmd_valid),
		.wr_cmd_kind     (wr_cmd_kind),
		.wr_cmd_address  (wr_cmd_address),
		.wr_cmd_lines    (wr_cmd_lines),
		.wr_data_0       (wr_data_0),
		.wr_data_1       (wr_data_1),
		.pf_cmd_valid    (pf_cmd_valid),
		.pf_cmd_address  (pf_cmd_address),
		.pf_cmd_lines    (pf_cmd_lines),
		.lines_done      (lines_done),
		.job_done        (job_done),
		.busy            (busy),
		.tests_done      (tests_done),
		.tests_failed    (tests_failed),
		.error_count     (value_errors)
	);

	bind write_engine_control write_engine_checker u_write_engine_checker (
		.clock             (clock),
		.rstn              (rstn),
		.wr_cmd_valid      (wr_cmd_valid),
		.wr_cmd_almost_full(wr_cmd_almost_full),
		.job_done          (job_done),
		.busy              (busy),
		.data_0_valid      (data_0_valid),
		.data_1_valid      (data_1_valid),
		.buf_0_full        (buf_0_full),
		.buf_1_full        (buf_1_full)
	);

	always #50 clock = ~clock;

	//////////////////////////////
	// Data source and responder
	//////////////////////////////

	function automatic logic [data_width-1:0] random_half();
		logic [data_width-1:0] value;
		int                    i;
		value = '0;
		for (i = 0; i < data_width / 32; i++)
			value[i*32 +: 32] = $random(seed);
		return value;
	endfunction

	// Index of the first response that is due, or -1
	function automatic int find_due(input int due [$], input int now);
		int i;
		for (i = 0; i < due.size(); i++) begin
			if (due[i] <= now)
				return i;
		end
		return -1;
	endfunction

	always @(posedge clock) begin
		if (rstn && (pushes_done < pushes_requested) && !data_full) begin
			data_0_valid <= 1'b1;
			data_1_valid <= 1'b1;
			data_0       <= random_half();
			data_1       <= random_half();
			pushes_done  <= pushes_done + 1;
		end else begin
			data_0_valid <= 1'b0;
			data_1_valid <= 1'b0;
		end
	end

	always @(posedge clock) begin
		if (apply_pressure) begin
			wr_cmd_almost_full <= (($random(seed) & 3) < 2);
			pf_cmd_almost_full <= (($random(seed) & 3) < 2);
		end else begin
			wr_cmd_almost_full <= 1'b0;
			pf_cmd_almost_full <= 1'b0;
		end
	end

	always @(posedge clock) begin : responder
		int idx;
		cycle_count++;
		wr_rsp_valid <= 1'b0;
		pf_rsp_valid <= 1'b0;
		if (wr_cmd_valid) begin
			wr_due.push_back(cycle_count + 1 + ($random(seed) & 7));
			wr_due_lines.push_back(wr_cmd_lines);
		end
		if (pf_cmd_valid)
			pf_due.push_back(cycle_count + 1 + ($random(seed) & 15));
		// At most one strobe per kind and cycle
		idx = find_due(wr_due, cycle_count);
		if (idx >= 0) begin
			wr_rsp_valid <= 1'b1;
			wr_rsp_lines <= wr_due_lines[idx];
			wr_due.delete(idx);
			wr_due_lines.delete(idx);
		end
		idx = find_due(pf_due, cycle_count);
		if (idx >= 0) begin
			pf_rsp_valid <= 1'b1;
			pf_due.delete(idx);
		end
	end

	//////////////////////////////
	// Job sequence
	//////////////////////////////

	task automatic wait_for_busy(input int row, output bit ok);
		int cycles;
		ok = 1'b0;
		for (cycles = 0; cycles < busy_timeout && !ok; cycles++) begin
			@(posedge clock);
			if (busy)
				ok = 1'b1;
		end
		if (!ok)
			$display("Timeout: busy never rose in test %0d", row);
	endtask

	task automatic wait_for_done(input int row, output bit ok);
		int cycles;
		ok = 1'b0;
		for (cycles = 0; cycles < done_timeout && !ok; cycles++) begin
			@(posedge clock);
			if (job_done)
				ok = 1'b1;
		end
		if (!ok)
			$display("Timeout: no job_done within %0d cycles in test %0d", done_timeout, row);
	endtask

	task automatic run_job(input int row, output bit ok);
		addr_t base;
		base = 64'h0000_0100_0000_0000 + (addr_t'(row) << 20);
		repeat (3) @(posedge clock);
		job_start        <= 1'b1;
		job_base         <= base;
		job_lines        <= lines_t'(tbl_lines[row]);
		job_prefetch     <= tbl_prefetch[row];
		job_allocate     <= tbl_allocate[row];
		expected_touches <= tbl_touches[row];
		apply_pressure   <= tbl_pressure[row];
		pushes_requested <= pushes_requested + tbl_lines[row];
		@(posedge clock);
		job_start <= 1'b0;
		ok = 1'b1;
		// Second start while busy must be ignored
		if (tbl_restart[row]) begin
			wait_for_busy(row, ok);
			if (ok) begin
				repeat (2) @(posedge clock);
				job_start    <= 1'b1;
				job_base     <= base + 64'h8000;
				job_lines    <= 16'd3;
				job_allocate <= !tbl_allocate[row];
				@(posedge clock);
				job_start <= 1'b0;
			end
		end
		if (ok)
			wait_for_done(row, ok);
		apply_pressure <= 1'b0;
	endtask

	initial begin : job_sequence
		int row;
		bit ok;
		int checker_errors;
		rstn = 1'b0;
		fill_table();
		repeat (2) @(posedge clock);
		rstn <= 1'b1;
		for (row = 0; row < num_jobs && !hung; row++) begin
			run_job(row, ok);
			if (!ok)
				hung = 1'b1;
		end
		repeat (4) @(posedge clock);
		checker_errors =
				u_write_engine_top.u_write_engine_control.u_write_engine_checker.fail_count;
		$display("Tests run %0d of %0d, failed %0d, value errors %0d, assertion failures %0d",
				tests_done, num_jobs, tests_failed, value_errors, checker_errors);
		if (hung || tests_done != num_jobs || tests_failed != 0 || value_errors != 0 ||
				checker_errors != 0) begin
			$display("Simulation finished: FAIL");
		end else begin
			$display("Simulation finished: PASS");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
logic/write_engine_pkg.sv
logic/sync_fifo.sv
logic/prefetch_page_sequencer.sv
logic/write_engine_control.sv
logic/write_engine_top.sv
tb/write_engine_checker.sv
tb/write_engine_monitor.sv
tb/write_engine_tb.sv

// File: Bender.yml
package:
  name: write_engine

sources:
  - logic/write_engine_pkg.sv
  - logic/sync_fifo.sv
  - logic/prefetch_page_sequencer.sv
  - logic/write_engine_control.sv
  - logic/write_engine_top.sv
  - target: simulation
    files:
      - tb/write_engine_checker.sv
      - tb/write_engine_monitor.sv
      - tb/write_engine_tb.sv
